// File: logic/axis_pkg.sv
// AXI4-Stream beat definitions
// Field widths of the stream and the packed beat that carries them
// through the mapper, the FIFO and the router of the switch

package axis_pkg;

  // ------------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------------

  // Payload width in bits
  parameter int DATA_W = 32;
  // One strobe/keep bit per data byte
  parameter int STRB_W = DATA_W / 8;
  // Stream identifier, also the route table index
  parameter int ID_W   = 4;
  // Destination, enough for four outputs
  parameter int DEST_W = 2;
  // Sideband user bits
  parameter int USER_W = 4;

  // ------------------------------------------------------------------
  // Beat
  // ------------------------------------------------------------------

  // One transfer on the stream, data in the upper bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [STRB_W-1:0] keep;
    // Marks the final beat of a packet
    logic              last;
    logic [ID_W-1:0]   id;
    // Filled in by the mapper, ignored at the input
    logic [DEST_W-1:0] dest;
    logic [USER_W-1:0] user;
  } beat_t;

endpackage

// File: logic/route_pkg.sv
// Route table definitions
// Entry type, table size and the configuration write that
// rewrites one entry of the destination lookup table

package route_pkg;

  // ------------------------------------------------------------------
  // Table layout
  // ------------------------------------------------------------------

  // One entry per possible tid
  parameter int TABLE_SIZE = 2 ** axis_pkg::ID_W;

  // Entry holds the destination output of one tid
  typedef logic [axis_pkg::DEST_W-1:0] route_entry_t;

  // ------------------------------------------------------------------
  // Configuration write
  // ------------------------------------------------------------------

  // Applied on the edge where the write strobe is high
  typedef struct packed {
    // Entry to rewrite
    logic [axis_pkg::ID_W-1:0] tid;
    // New destination for that tid
    route_entry_t              dest;
  } cfg_wr_t;

endpackage

// File: logic/dest_mapper.sv
// Destination mapper
// Looks up the output of each beat from its tid in a writable route
// table and stamps it into tdest. One register stage sits between
// the input and the FIFO, with full throughput under valid/ready.

`timescale 1ns/1ps

module dest_mapper #(
  parameter int NR_DEST = 4
) (
  input  logic                clk,
  input  logic                rst_n,

  // Incoming stream, dest field is don't care
  input  logic                in_valid,
  output logic                in_ready,
  input  axis_pkg::beat_t     in_beat,

  // Route table write strobe
  input  logic                cfg_wr,
  input  route_pkg::cfg_wr_t  cfg,

  // Routed stream towards the FIFO
  output logic                map_valid,
  input  logic                map_ready,
  output axis_pkg::beat_t     map_beat
);

  // ------------------------------------------------------------------
  // Route table
  // ------------------------------------------------------------------

  route_pkg::route_entry_t route_table [route_pkg::TABLE_SIZE];

  logic            accept;
  axis_pkg::beat_t stamped;

  // Default spreads tids round robin over the outputs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < route_pkg::TABLE_SIZE; i++) begin
        route_table[i] <= route_pkg::route_entry_t'(i % NR_DEST);
      end
    end else if (cfg_wr) begin
      route_table[cfg.tid] <= cfg.dest;
    end
  end

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------

  // Register free, or draining in this same cycle
  assign in_ready = !map_valid || map_ready;
  assign accept   = in_valid && in_ready;

  // Table read happens at acceptance, before any write on this edge
  always_comb begin
    stamped      = in_beat;
    stamped.dest = route_table[in_beat.id];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      map_valid <= 1'b0;
    end else if (accept) begin
      map_valid <= 1'b1;
    end else if (map_ready) begin
      map_valid <= 1'b0;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      map_beat <= stamped;
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Stalled beat must be held unchanged until the FIFO takes it
  a_map_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    map_valid && !map_ready |=> map_valid && $stable(map_beat)
  ) else $error("dest_mapper: beat changed under back-pressure");

endmodule

// File: logic/beat_fifo.sv
// Beat FIFO
// Synchronous circular buffer of stream beats with valid/ready on
// both sides. Pointers carry one extra wrap bit so that full and
// empty can be told apart. First-word latency is one cycle.

`timescale 1ns/1ps

module beat_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst_n,

  // Write side
  input  logic            wr_valid,
  output logic            wr_ready,
  input  axis_pkg::beat_t wr_beat,

  // Read side
  output logic            rd_valid,
  input  logic            rd_ready,
  output axis_pkg::beat_t rd_beat
);

  // Index width, pointers are one bit wider
  localparam int AW = $clog2(FIFO_DEPTH);

  // ------------------------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------------------------

  axis_pkg::beat_t mem [FIFO_DEPTH];

  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] fill;
  logic        full;
  logic        empty;
  logic        wr_en;
  logic        rd_en;

  // Wrap bit makes the difference the true occupancy
  assign fill  = wr_ptr - rd_ptr;
  assign full  = (fill == (AW + 1)'(FIFO_DEPTH));
  assign empty = (fill == '0);

  // Ready only depends on occupancy
  assign wr_ready = !full;
  assign rd_valid = !empty;

  assign wr_en = wr_valid && wr_ready;
  assign rd_en = rd_valid && rd_ready;

  // Head of the queue, shown as soon as it is written
  assign rd_beat = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= wr_beat;
    end
  end

  // Both pointers may step on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Nothing gets written while full
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    full |=> wr_ptr == $past(wr_ptr)
  ) else $error("beat_fifo: write while full");

  // Nothing gets read while empty
  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    empty |=> rd_ptr == $past(rd_ptr)
  ) else $error("beat_fifo: read while empty");

endmodule

// File: logic/dest_router.sv
// Destination router
// Packet-locked demultiplexer. The tdest of a packet's first beat is
// latched and the whole packet is steered to that output until the
// beat with tlast transfers. All outputs share one beat bus and
// have their own valid and ready. Costs one idle cycle per packet.

`timescale 1ns/1ps

module dest_router #(
  parameter int NR_DEST = 4
) (
  input  logic               clk,
  input  logic               rst_n,

  // From the FIFO
  input  logic               fifo_valid,
  output logic               fifo_ready,
  input  axis_pkg::beat_t    fifo_beat,

  // To the sinks
  output logic [NR_DEST-1:0] out_valid,
  input  logic [NR_DEST-1:0] out_ready,
  output axis_pkg::beat_t    out_beat
);

  typedef enum logic {
    WAIT_FIRST,
    WAIT_LAST
  } router_state_t;

  router_state_t               state;
  logic [axis_pkg::DEST_W-1:0] dest_sel;
  logic                        last_xfer;

  // Final beat of the packet leaves on this edge
  assign last_xfer = fifo_valid && fifo_ready && fifo_beat.last;

  // ------------------------------------------------------------------
  // Packet lock FSM
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= WAIT_FIRST;
      dest_sel <= '0;
    end else begin
      case (state)
        WAIT_FIRST: begin
          // Lock on the head beat, forwarding starts next cycle
          if (fifo_valid) begin
            state    <= WAIT_LAST;
            dest_sel <= fifo_beat.dest;
          end
        end
        WAIT_LAST: begin
          if (last_xfer) begin
            state <= WAIT_FIRST;
          end
        end
        default: begin
          state <= WAIT_FIRST;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Output steering
  // ------------------------------------------------------------------

  // Shared bus, only the selected valid qualifies it
  assign out_beat = fifo_beat;

  always_comb begin
    out_valid  = '0;
    fifo_ready = 1'b0;
    if (state == WAIT_LAST) begin
      for (int i = 0; i < NR_DEST; i++) begin
        if (dest_sel == axis_pkg::DEST_W'(i)) begin
          out_valid[i] = fifo_valid;
          fifo_ready   = out_ready[i];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // At most one output sees valid
  a_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(out_valid)
  ) else $error("dest_router: more than one out_valid");

  // Route table only holds reachable outputs
  a_dest_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    state == WAIT_LAST |-> dest_sel < NR_DEST
  ) else $error("dest_router: latched dest %0d out of range", dest_sel);

endmodule

// File: logic/stream_switch.sv
// AXI4-Stream switch
// Single input stream routed by tid to one of NR_DEST outputs.
// Chain is mapper, then FIFO, then the packet-locked router.
// Three cycles from input acceptance to the first possible output.

`timescale 1ns/1ps

module stream_switch #(
  parameter int NR_DEST    = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               rst_n,

  // Input stream
  input  logic               in_valid,
  output logic               in_ready,
  input  axis_pkg::beat_t    in_beat,

  // Route table write
  input  logic               cfg_wr,
  input  route_pkg::cfg_wr_t cfg,

  // Output streams on one shared beat bus
  output logic [NR_DEST-1:0] out_valid,
  input  logic [NR_DEST-1:0] out_ready,
  output axis_pkg::beat_t    out_beat
);

  // ------------------------------------------------------------------
  // Inter-stage wires
  // ------------------------------------------------------------------

  // Mapper to FIFO
  logic            map_valid;
  logic            map_ready;
  axis_pkg::beat_t map_beat;

  // FIFO to router
  logic            fifo_valid;
  logic            fifo_ready;
  axis_pkg::beat_t fifo_beat;

  dest_mapper #(
    .NR_DEST (NR_DEST)
  ) u_dest_mapper (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .cfg_wr    (cfg_wr),
    .cfg       (cfg),
    .map_valid (map_valid),
    .map_ready (map_ready),
    .map_beat  (map_beat)
  );

  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_beat_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (map_valid),
    .wr_ready (map_ready),
    .wr_beat  (map_beat),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready),
    .rd_beat  (fifo_beat)
  );

  dest_router #(
    .NR_DEST (NR_DEST)
  ) u_dest_router (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .fifo_beat  (fifo_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

// File: include/tb_compare.svh
// Testbench compare helpers for the stream switch
// Typed compare tasks for beats, valid vectors and single flags,
// the check and error counters, and the xorshift random source

`ifndef TB_COMPARE_SVH
`define TB_COMPARE_SVH

  int          check_count = 0;
  int          error_count = 0;
  // Xorshift state, fixed seed
  logic [31:0] rng_state   = 32'ha366_a2f4;

  // ------------------------------------------------------------------
  // Random source
  // ------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------

  // Whole beat, all fields at once
  task automatic compare_beat(input axis_pkg::beat_t expected, input axis_pkg::beat_t actual,
                              input string name);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED time %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // One valid bit per output
  task automatic compare_valid(input logic [NR_DEST-1:0] expected,
                               input logic [NR_DEST-1:0] actual, input string name);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED time %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_flag(input logic expected, input logic actual, input string name);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED time %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

`endif

// File: test/stream_switch_tb.sv
// Testbench for the AXI4-Stream switch
// Directed tests drive packets into the switch; a scoreboard holds the
// expected beats per output, with destinations from a model copy of
// the route table. Outputs are sampled on the falling edge.

`timescale 1ns/1ps

module stream_switch_tb;

  localparam int NR_DEST    = 4;
  localparam int FIFO_DEPTH = 8;
  // More beats than mapper register and FIFO can hold together
  localparam int FILL_BEATS = FIFO_DEPTH + 4;
  // Rough length of all tests, limit leaves room for random stalls
  localparam int EST_CYCLES = 1500;
  localparam int MAX_CYCLES = EST_CYCLES * 8 / 3;

  typedef logic [axis_pkg::ID_W-1:0] tid_t;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  logic               in_ready;
  axis_pkg::beat_t    in_beat;
  logic               cfg_wr;
  route_pkg::cfg_wr_t cfg;
  logic [NR_DEST-1:0] out_valid;
  logic [NR_DEST-1:0] out_ready;
  axis_pkg::beat_t    out_beat;

  // Scoreboard, one queue per output plus the order of packets
  axis_pkg::beat_t         exp_q [NR_DEST][$];
  int                      pkt_dest_q [$];
  route_pkg::route_entry_t model_table [route_pkg::TABLE_SIZE];
  axis_pkg::beat_t         exp_beat;
  logic [NR_DEST-1:0]      want_valid;
  int                      accepted_cnt = 0;
  int                      cycle_count  = 0;

  `include "tb_compare.svh"

  stream_switch #(
    .NR_DEST    (NR_DEST),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .cfg_wr    (cfg_wr),
    .cfg       (cfg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------------

  // Inputs only move on the rising edge, so these values hold at the next one
  always @(negedge clk) begin
    if (rst_n) begin
      // Only the output of the packet at the head may see valid
      if (out_valid != '0) begin
        if (pkt_dest_q.size() == 0) begin
          error_count++;
          $display("out_valid raised at %0t with no packet outstanding", $time);
        end else begin
          want_valid = '0;
          want_valid[pkt_dest_q[0]] = 1'b1;
          compare_valid(want_valid, out_valid, "out_valid");
        end
      end
      for (int i = 0; i < NR_DEST; i++) begin
        if (out_valid[i] && out_ready[i]) begin
          if (exp_q[i].size() == 0) begin
            error_count++;
            $display("Beat on output %0d at %0t where none was expected", i, $time);
          end else begin
            exp_beat = exp_q[i].pop_front();
            compare_beat(exp_beat, out_beat, $sformatf("out_beat[%0d]", i));
          end
          if (out_beat.last && pkt_dest_q.size() != 0) begin
            void'(pkt_dest_q.pop_front());
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------------

  // Random payload, input dest is junk that the mapper must replace
  function automatic axis_pkg::beat_t make_beat(input tid_t id, input logic last);
    axis_pkg::beat_t b;
    logic [31:0]     r;
    r      = next_random();
    b.data = next_random();
    b.strb = r[3:0];
    b.keep = r[7:4];
    b.user = r[11:8];
    b.dest = r[13:12];
    b.last = last;
    b.id   = id;
    return b;
  endfunction

  // Returns on the falling edge before the accepting rising edge
  task automatic send_beat(input axis_pkg::beat_t b);
    @(posedge clk);
    in_beat  <= b;
    in_valid <= 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    accepted_cnt++;
  endtask

  // Model takes effect for beats accepted after the strobe edge
  task automatic write_route(input tid_t tid, input route_pkg::route_entry_t dest);
    @(posedge clk);
    in_valid <= 1'b0;
    cfg.tid  <= tid;
    cfg.dest <= dest;
    cfg_wr   <= 1'b1;
    @(posedge clk);
    cfg_wr <= 1'b0;
    model_table[tid] = dest;
  endtask

  // Output fixed by the first beat, dest field stamped per beat
  task automatic send_packet(input tid_t id, input int nbeats, input int wr_at,
                             input route_pkg::route_entry_t wr_dest);
    axis_pkg::beat_t b;
    int              pdest;
    pdest = int'(model_table[id]);
    pkt_dest_q.push_back(pdest);
    for (int n = 0; n < nbeats; n++) begin
      if (n == wr_at) begin
        write_route(id, wr_dest);
      end
      b = make_beat(id, n == nbeats - 1);
      send_beat(b);
      b.dest = model_table[id];
      exp_q[pdest].push_back(b);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain;
    int left;
    do begin
      @(posedge clk);
      left = pkt_dest_q.size();
      for (int i = 0; i < NR_DEST; i++) begin
        left += exp_q[i].size();
      end
    end while (left != 0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errs_before);
    end
  endtask

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  task automatic check_reset_routing;
    int errs;
    errs = error_count;
    @(negedge clk);
    compare_valid('0, out_valid, "out_valid");
    compare_flag(1'b1, in_ready, "in_ready");
    for (int t = 0; t < 8; t++) begin
      send_packet(tid_t'(t), 1, -1, '0);
    end
    wait_drain();
    report_test("reset routing", errs);
  endtask

  task automatic redirect_route;
    int errs;
    errs = error_count;
    write_route(tid_t'(5), route_pkg::route_entry_t'(3));
    for (int n = 0; n < 3; n++) begin
      send_packet(tid_t'(5), 1, -1, '0);
    end
    // Neighbouring tid keeps its default
    send_packet(tid_t'(4), 1, -1, '0);
    wait_drain();
    report_test("route write", errs);
  endtask

  task automatic lock_packet;
    int errs;
    errs = error_count;
    // Table changes before beat 2, packet stays on output 2
    send_packet(tid_t'(6), 4, 2, route_pkg::route_entry_t'(1));
    send_packet(tid_t'(6), 1, -1, '0);
    wait_drain();
    report_test("packet lock", errs);
  endtask

  task automatic stall_output;
    int                 errs;
    int                 target;
    bit                 done;
    logic [31:0]        r;
    logic [NR_DEST-1:0] rdy;
    errs   = error_count;
    target = int'(model_table[1]);
    done   = 1'b0;
    fork
      begin
        send_packet(tid_t'(1), 6, -1, '0);
        send_packet(tid_t'(9), 6, -1, '0);
        wait_drain();
        done = 1'b1;
      end
      while (!done) begin
        @(posedge clk);
        r           = next_random();
        rdy         = '1;
        rdy[target] = r[0];
        out_ready <= rdy;
      end
    join
    @(posedge clk);
    out_ready <= '1;
    report_test("back-pressure", errs);
  endtask

  task automatic fill_fifo;
    int errs;
    int start_cnt;
    int held;
    int waited;
    bit stalled;
    errs = error_count;
    @(posedge clk);
    out_ready <= '0;
    start_cnt = accepted_cnt;
    stalled   = 1'b0;
    waited    = 0;
    fork
      send_packet(tid_t'(3), FILL_BEATS, -1, '0);
      begin
        while (!stalled && waited < 4 * FILL_BEATS) begin
          @(negedge clk);
          waited++;
          stalled = in_valid && !in_ready;
        end
        held = accepted_cnt - start_cnt;
        if (!stalled) begin
          error_count++;
          $display("in_ready never dropped with all outputs stalled");
        end else if (held > FIFO_DEPTH + 2) begin
          error_count++;
          $display("in_ready dropped only after %0d accepted beats", held);
        end
        // Stay stalled a while before the sinks open
        repeat (8) @(negedge clk);
        @(posedge clk);
        out_ready <= '1;
      end
    join
    wait_drain();
    report_test("FIFO fill", errs);
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    cfg_wr    = 1'b0;
    cfg       = '0;
    out_ready = '1;
    for (int i = 0; i < route_pkg::TABLE_SIZE; i++) begin
      model_table[i] = route_pkg::route_entry_t'(i % NR_DEST);
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_routing();
    redirect_route();
    lock_packet();
    stall_output();
    fill_fifo();
    repeat (4) @(posedge clk);
    $display("Summary: %0d checks, %0d errors, %0d beats sent, %0d cycles",
             check_count, error_count, accepted_cnt, cycle_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: stream_switch.f
+incdir+include
logic/axis_pkg.sv
logic/route_pkg.sv
logic/dest_mapper.sv
logic/beat_fifo.sv
logic/dest_router.sv
logic/stream_switch.sv
test/stream_switch_tb.sv

// File: Makefile
# Verilator build and run of the stream switch testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = stream_switch_tb
FILELIST  = stream_switch.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails on a non-zero exit or when the log holds the fail message
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
